/* include/lcd_consts.svh */
`ifndef LCD_CONSTS_SVH
`define LCD_CONSTS_SVH

// step counter width
`define LCD_CT_W 23

// ILI9341 command bytes
`define LCD_CMD_SWRST    8'h01
`define LCD_CMD_SLPOUT   8'h11
`define LCD_CMD_SLPIN    8'h10
`define LCD_CMD_DISPON   8'h29
`define LCD_CMD_DISPOFF  8'h28
`define LCD_CMD_COLADDR  8'h2A
`define LCD_CMD_PAGEADDR 8'h2B
`define LCD_CMD_MEMWR    8'h2C
`define LCD_CMD_PIXFMT   8'h3A
`define LCD_CMD_MADCTL   8'h36

// parameter bytes
`define LCD_PAR_PIXFMT 8'h55 // 16 bit per pixel, both interfaces
`define LCD_PAR_MADCTL 8'hB8 // landscape, BGR order

// RGB565 colours, high byte first
`define LCD_RED_HI   8'hF8
`define LCD_RED_LO   8'h00
`define LCD_GREEN_HI 8'h07
`define LCD_GREEN_LO 8'hE0
`define LCD_BLUE_HI  8'h00
`define LCD_BLUE_LO  8'h1F
`define LCD_BLACK_HI 8'h00
`define LCD_BLACK_LO 8'h00
`define LCD_WHITE_HI 8'hFF
`define LCD_WHITE_LO 8'hFF

// wait counts in clock steps
`define LCD_OFF_WAIT 40 // panel value 100000
`define LCD_ON_WAIT  60 // panel value 1200000

// pixels written by a full clear
`define LCD_CLEAR_PIXELS 16 // panel value 76800

`endif

/* source/lcdPkg.sv */
package lcdPkg;

  // host opcodes, value doubles as the controlBus bit index
  typedef enum logic [3:0] {
    opNone    = 4'd0,
    opInit    = 4'd1,
    opDispOff = 4'd2,
    opDispOn  = 4'd3,
    opClear   = 4'd4,
    opRed     = 4'd5,
    opGreen   = 4'd6,
    opBlue    = 4'd7,
    opBlack   = 4'd8,
    opWhite   = 4'd9
  } lcdOp_t;

  // command selector
  typedef enum logic {
    sIdle = 1'b0,
    sRun  = 1'b1
  } selState_t;

endpackage

/* source/lcdCommandSelect.sv */
`timescale 1ns/100ps

module lcdCommandSelect (
  input  logic           clk,
  input  logic           rst,
  input  logic           req,
  input  lcdPkg::lcdOp_t op,
  input  logic [31:0]    xWin,
  input  logic [31:0]    yWin,
  input  logic           ack,
  output logic [31:0]    controlBus,
  output logic [31:0]    xBus,
  output logic [31:0]    yBus,
  output logic           busy
);
  import lcdPkg::*;

  selState_t state;
  selState_t nextState;
  logic accept;

  assign accept = req && (op != opNone) && (state == sIdle); // requests in sRun are dropped
  assign busy = (state == sRun);

  always_comb begin
    nextState = state;
    case (state)
      sIdle: begin
        if (accept) begin
          nextState = sRun;
        end
      end
      sRun: begin
        if (ack) begin
          nextState = sIdle;
        end
      end
      default: nextState = sIdle;
    endcase
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state <= sIdle;
      controlBus <= '0;
    end else begin
      state <= nextState;
      if (accept) begin
        controlBus <= 32'd1 << op; // one-hot level held until ack
      end else if (ack && (state == sRun)) begin
        controlBus <= '0;
      end
    end
  end

  // window payload, only sampled on acceptance
  always_ff @(posedge clk) begin
    if (accept) begin
      xBus <= xWin;
      yBus <= yWin;
    end
  end

  assert property (@(posedge clk) disable iff (rst)
    $onehot0(controlBus) && (busy == (|controlBus)))
    else $error("controlBus not one-hot or out of step with busy");

  assert property (@(posedge clk) disable iff (rst)
    ack |-> busy ##1 !busy)
    else $error("ack outside a running command");

endmodule

/* source/lcdCycleCounter.sv */
`timescale 1ns/100ps
`include "lcd_consts.svh"

module lcdCycleCounter (
  input  logic                 clk,
  input  logic                 rst,
  input  logic [31:0]          controlBus,
  output logic [`LCD_CT_W-1:0] ct
);

  logic [`LCD_CT_W-1:0] count;
  logic active;

  assign active = |controlBus;
  assign ct = active ? count : '0; // drops to zero with the command

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      count <= '0;
    end else if (!active) begin
      count <= '0;
    end else if (count != '1) begin
      count <= count + 1'b1; // saturating
    end
  end

  assert property (@(posedge clk) disable iff (rst)
    $changed(controlBus) |-> ct == '0)
    else $error("ct not at zero when a command starts or ends");

  assert property (@(posedge clk) disable iff (rst)
    active && $past(active) && ($past(count) != '1) |-> ct == $past(ct) + 1'b1)
    else $error("ct skipped a step");

endmodule

/* source/screenSignalLogic.sv */
`timescale 1ns/100ps
`include "lcd_consts.svh"

module screenSignalLogic (
  input  logic                 clk,
  input  logic                 rst,
  input  logic [31:0]          controlBus,
  input  logic [31:0]          xBus,
  input  logic [31:0]          yBus,
  input  logic [`LCD_CT_W-1:0] ct,
  output logic                 ack,
  output logic                 dcx,
  output logic                 wrx,
  output logic                 csx,
  output logic [7:0]           data
);
  import lcdPkg::*;

  localparam logic [`LCD_CT_W-1:0] initAck = 22;
  localparam logic [`LCD_CT_W-1:0] pixStart = 30; // first step after window prefix
  localparam logic [`LCD_CT_W-1:0] fillAck = 35;
  localparam logic [`LCD_CT_W-1:0] offSlpIn = `LCD_OFF_WAIT + 3;
  localparam logic [`LCD_CT_W-1:0] offAck = 2 * `LCD_OFF_WAIT + 5;
  localparam logic [`LCD_CT_W-1:0] onAck = `LCD_ON_WAIT + `LCD_ON_WAIT / 24 + 1;
  localparam logic [`LCD_CT_W-1:0] clrEnd = 30 + 7 * `LCD_CLEAR_PIXELS;
  localparam logic [31:0] fullCol = 32'h0000_013F; // columns 0..319
  localparam logic [31:0] fullPage = 32'h0000_00EF; // pages 0..239

  logic nextCsx;
  logic nextDcx;
  logic nextWrx;
  logic [7:0] nextData;
  logic [8:0] wrReq; // write strobe and byte
  logic fillOp;
  logic winOp;
  logic [31:0] winX;
  logic [31:0] winY;
  logic [7:0] pixHi;
  logic [7:0] pixLo;
  logic [`LCD_CT_W-1:0] pixStep;
  logic [2:0] pixPhase;

  assign fillOp = controlBus[opRed] | controlBus[opGreen] | controlBus[opBlue]
                | controlBus[opBlack] | controlBus[opWhite];
  assign winOp = fillOp | controlBus[opClear];
  assign winX = controlBus[opClear] ? fullCol : xBus;
  assign winY = controlBus[opClear] ? fullPage : yBus;
  assign pixStep = ct - pixStart;
  assign pixPhase = 3'(pixStep % 7); // position inside a clear pixel

  always_comb begin
    case (1'b1)
      controlBus[opRed]: begin
        pixHi = `LCD_RED_HI;
        pixLo = `LCD_RED_LO;
      end
      controlBus[opGreen]: begin
        pixHi = `LCD_GREEN_HI;
        pixLo = `LCD_GREEN_LO;
      end
      controlBus[opBlue]: begin
        pixHi = `LCD_BLUE_HI;
        pixLo = `LCD_BLUE_LO;
      end
      controlBus[opWhite]: begin
        pixHi = `LCD_WHITE_HI;
        pixLo = `LCD_WHITE_LO;
      end
      default: begin
        pixHi = `LCD_BLACK_HI;
        pixLo = `LCD_BLACK_LO;
      end
    endcase
  end

  // wrx idles high, a write pulls it low for one step only
  always_comb begin
    nextCsx = csx;
    nextDcx = dcx;
    nextData = data;
    wrReq = '0;
    ack = 1'b0;

    if (ct == '0) begin // park the bus, also while idle
      nextCsx = 1'b1;
      nextDcx = 1'b1;
      nextData = 8'h00;
    end

    if (controlBus[opInit]) begin
      case (ct)
        1: nextCsx = 1'b0;
        2: nextDcx = 1'b0;
        3: wrReq = {1'b1, `LCD_CMD_SWRST};
        5: wrReq = {1'b1, `LCD_CMD_SLPOUT};
        7: wrReq = {1'b1, `LCD_CMD_PIXFMT};
        9: nextDcx = 1'b1;
        10: wrReq = {1'b1, `LCD_PAR_PIXFMT};
        12: nextDcx = 1'b0;
        13: wrReq = {1'b1, `LCD_CMD_MADCTL};
        15: nextDcx = 1'b1;
        16: wrReq = {1'b1, `LCD_PAR_MADCTL};
        18: nextDcx = 1'b0;
        19: wrReq = {1'b1, `LCD_CMD_DISPON};
        initAck - 1: nextCsx = 1'b1;
        initAck: ack = 1'b1;
        default: ;
      endcase
    end else if (controlBus[opDispOff]) begin
      case (ct)
        1: nextCsx = 1'b0;
        2: nextDcx = 1'b0;
        3: wrReq = {1'b1, `LCD_CMD_DISPOFF};
        offSlpIn: wrReq = {1'b1, `LCD_CMD_SLPIN}; // after the off wait
        offAck - 1: nextCsx = 1'b1; // sleep-in settle
        offAck: ack = 1'b1;
        default: ;
      endcase
    end else if (controlBus[opDispOn]) begin
      case (ct)
        1: nextCsx = 1'b0;
        2: nextDcx = 1'b0;
        3: wrReq = {1'b1, `LCD_CMD_SLPOUT};
        onAck - 3: wrReq = {1'b1, `LCD_CMD_DISPON}; // panel out of sleep by now
        onAck - 1: nextCsx = 1'b1;
        onAck: ack = 1'b1;
        default: ;
      endcase
    end else if (winOp) begin
      if (ct < pixStart) begin
        case (ct)
          1: nextCsx = 1'b0;
          2: nextDcx = 1'b0;
          3: wrReq = {1'b1, `LCD_CMD_COLADDR};
          5: nextDcx = 1'b1;
          6: wrReq = {1'b1, winX[31:24]};
          8: wrReq = {1'b1, winX[23:16]};
          10: wrReq = {1'b1, winX[15:8]};
          12: wrReq = {1'b1, winX[7:0]};
          14: nextDcx = 1'b0;
          15: wrReq = {1'b1, `LCD_CMD_PAGEADDR};
          17: nextDcx = 1'b1;
          18: wrReq = {1'b1, winY[31:24]};
          20: wrReq = {1'b1, winY[23:16]};
          22: wrReq = {1'b1, winY[15:8]};
          24: wrReq = {1'b1, winY[7:0]};
          26: nextDcx = 1'b0;
          27: wrReq = {1'b1, `LCD_CMD_MEMWR};
          29: nextDcx = 1'b1; // pixel data follows
          default: ;
        endcase
      end else if (fillOp) begin
        case (ct)
          pixStart: wrReq = {1'b1, pixHi};
          pixStart + 2: wrReq = {1'b1, pixLo};
          fillAck - 1: nextCsx = 1'b1;
          fillAck: ack = 1'b1;
          default: ;
        endcase
      end else if (ct < clrEnd) begin
        if (pixPhase == 3'd2) begin
          wrReq = {1'b1, `LCD_WHITE_HI};
        end else if (pixPhase == 3'd6) begin
          wrReq = {1'b1, `LCD_WHITE_LO};
        end
      end else if (ct == clrEnd + 1) begin
        nextCsx = 1'b1;
      end else if (ct == clrEnd + 2) begin
        ack = 1'b1;
      end
    end

    nextWrx = !wrReq[8];
    if (wrReq[8]) begin
      nextData = wrReq[7:0];
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      csx <= 1'b1;
      dcx <= 1'b1;
      wrx <= 1'b1;
      data <= 8'h00;
    end else begin
      csx <= nextCsx;
      dcx <= nextDcx;
      wrx <= nextWrx;
      data <= nextData;
    end
  end

  // byte must be stable around the rising wrx edge
  assert property (@(posedge clk) disable iff (rst)
    $changed(data) |-> !wrx || csx)
    else $error("data moved while a write was latching");

  assert property (@(posedge clk) disable iff (rst)
    ack |-> csx && wrx)
    else $error("ack before the bus was released");

endmodule

/* source/lcdTop.sv */
`timescale 1ns/100ps
`include "lcd_consts.svh"

module lcdTop (
  input  logic           clk,
  input  logic           rst,
  input  logic           req,
  input  lcdPkg::lcdOp_t op,
  input  logic [31:0]    xWin,
  input  logic [31:0]    yWin,
  output logic           busy,
  output logic           ack,
  output logic           csx,
  output logic           dcx,
  output logic           wrx,
  output logic [7:0]     data
);

  logic [31:0] controlBus;
  logic [31:0] xBus;
  logic [31:0] yBus;
  logic [`LCD_CT_W-1:0] ct;

  lcdCommandSelect cmdSelect (
    .clk        (clk),
    .rst        (rst),
    .req        (req),
    .op         (op),
    .xWin       (xWin),
    .yWin       (yWin),
    .ack        (ack),
    .controlBus (controlBus),
    .xBus       (xBus),
    .yBus       (yBus),
    .busy       (busy)
  );

  lcdCycleCounter cycleCounter (
    .clk        (clk),
    .rst        (rst),
    .controlBus (controlBus),
    .ct         (ct)
  );

  screenSignalLogic signalLogic (
    .clk        (clk),
    .rst        (rst),
    .controlBus (controlBus),
    .xBus       (xBus),
    .yBus       (yBus),
    .ct         (ct),
    .ack        (ack),
    .dcx        (dcx),
    .wrx        (wrx),
    .csx        (csx),
    .data       (data)
  );

endmodule

/* verification/lcdTb.sv */
`timescale 1ns/100ps
`include "lcd_consts.svh"

module lcdTb;
  import lcdPkg::*;

  typedef logic [8:0] pairQ_t[$]; // {dcx, data} per panel write

  localparam int clkPeriod = 4;

  logic clk;
  logic rst;
  logic req;
  lcdOp_t op;
  logic [31:0] xWin;
  logic [31:0] yWin;
  logic busy;
  logic ack;
  logic csx;
  logic dcx;
  logic wrx;
  logic [7:0] data;

  pairQ_t expQ;
  pairQ_t actQ;
  logic prevWrx;
  logic [31:0] rngState;
  int ackCount;
  int accepted;
  int byteErrors;
  int ctrlErrors;

  lcdTop UUT (
    .clk  (clk),
    .rst  (rst),
    .req  (req),
    .op   (op),
    .xWin (xWin),
    .yWin (yWin),
    .busy (busy),
    .ack  (ack),
    .csx  (csx),
    .dcx  (dcx),
    .wrx  (wrx),
    .data (data)
  );

  always #(clkPeriod / 2) clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] v;
    v = s ^ (s << 13);
    v = v ^ (v >> 17);
    v = v ^ (v << 5);
    return v;
  endfunction

  // ack step, counted from the first busy cycle
  function automatic int ackStep(input lcdOp_t o);
    case (o)
      opNone: return 0;
      opInit: return 22;
      opDispOff: return 2 * `LCD_OFF_WAIT + 5;
      opDispOn: return `LCD_ON_WAIT + `LCD_ON_WAIT / 24 + 1;
      opClear: return 30 + 7 * `LCD_CLEAR_PIXELS + 2;
      default: return 35; // colour fills
    endcase
  endfunction

  function automatic pairQ_t expectedBytes(input lcdOp_t o, input logic [31:0] x,
                                           input logic [31:0] y);
    pairQ_t q;
    logic [15:0] pix;
    logic [31:0] cols;
    logic [31:0] pages;
    int n;
    int i;
    case (o)
      opNone: ;
      opInit: begin
        q.push_back({1'b0, `LCD_CMD_SWRST});
        q.push_back({1'b0, `LCD_CMD_SLPOUT});
        q.push_back({1'b0, `LCD_CMD_PIXFMT});
        q.push_back({1'b1, `LCD_PAR_PIXFMT});
        q.push_back({1'b0, `LCD_CMD_MADCTL});
        q.push_back({1'b1, `LCD_PAR_MADCTL});
        q.push_back({1'b0, `LCD_CMD_DISPON});
      end
      opDispOff: begin
        q.push_back({1'b0, `LCD_CMD_DISPOFF});
        q.push_back({1'b0, `LCD_CMD_SLPIN});
      end
      opDispOn: begin
        q.push_back({1'b0, `LCD_CMD_SLPOUT});
        q.push_back({1'b0, `LCD_CMD_DISPON});
      end
      default: begin
        cols = (o == opClear) ? 32'h0000_013F : x; // 320 x 240 panel
        pages = (o == opClear) ? 32'h0000_00EF : y;
        case (o)
          opRed: pix = {`LCD_RED_HI, `LCD_RED_LO};
          opGreen: pix = {`LCD_GREEN_HI, `LCD_GREEN_LO};
          opBlue: pix = {`LCD_BLUE_HI, `LCD_BLUE_LO};
          opBlack: pix = {`LCD_BLACK_HI, `LCD_BLACK_LO};
          default: pix = {`LCD_WHITE_HI, `LCD_WHITE_LO}; // white and clear
        endcase
        n = (o == opClear) ? `LCD_CLEAR_PIXELS : 1;
        q.push_back({1'b0, `LCD_CMD_COLADDR});
        for (i = 3; i >= 0; i--) begin
          q.push_back({1'b1, cols[8*i +: 8]}); // msb first
        end
        q.push_back({1'b0, `LCD_CMD_PAGEADDR});
        for (i = 3; i >= 0; i--) begin
          q.push_back({1'b1, pages[8*i +: 8]});
        end
        q.push_back({1'b0, `LCD_CMD_MEMWR});
        for (i = 0; i < n; i++) begin
          q.push_back({1'b1, pix[15:8]});
          q.push_back({1'b1, pix[7:0]});
        end
      end
    endcase
    return q;
  endfunction

  task automatic checkSignal(input string name, input logic [31:0] expVal,
                             input logic [31:0] actVal);
    assert (actVal === expVal) else begin
      ctrlErrors++;
      $display("[FAIL] %0t %s expected %0h got %0h", $time, name, expVal, actVal);
    end
  endtask

  // one accepted request, optional dropped requests while it runs
  task automatic runOp(input lcdOp_t o, input logic [31:0] x, input logic [31:0] y,
                       input bit dropMid);
    pairQ_t exp;
    int busyCycles;
    int ackBefore;
    int minBusy;
    exp = expectedBytes(o, x, y);
    foreach (exp[i]) begin
      expQ.push_back(exp[i]);
    end
    ackBefore = ackCount;
    busyCycles = 0;
    @(posedge clk);
    req <= 1'b1;
    op <= o;
    xWin <= x;
    yWin <= y;
    @(posedge clk);
    req <= 1'b0;
    op <= opNone;
    accepted++;
    do begin
      @(posedge clk);
      if (busy) begin
        busyCycles++;
      end
      req <= 1'b0;
      op <= opNone;
      if (dropMid && (busyCycles == 4 || busyCycles == ackStep(o))) begin
        req <= 1'b1;
        xWin <= ~x; // must not reach the latched window
        if (busyCycles == 4) begin
          op <= opInit;
        end else begin
          op <= opClear; // lands in the ack cycle
        end
      end
    end while (!ack);
    checkSignal("busy cycles", ackStep(o) + 1, busyCycles);
    if (o == opDispOff || o == opDispOn) begin
      minBusy = (o == opDispOff) ? `LCD_OFF_WAIT : `LCD_ON_WAIT;
      assert (busyCycles >= minBusy) else begin
        ctrlErrors++;
        $display("busy ended after %0d cycles, before the panel wait of %0d", busyCycles,
                 minBusy);
      end
    end
    repeat (2) @(posedge clk);
    checkSignal("busy", 0, busy);
    checkSignal("ack pulses", 1, ackCount - ackBefore);
  endtask

  task automatic sendNoneRequest();
    @(posedge clk);
    req <= 1'b1;
    op <= opNone;
    @(posedge clk);
    req <= 1'b0;
    repeat (3) @(posedge clk);
    checkSignal("busy", 0, busy);
  endtask

  // bus monitor, samples the registered pins on the clock
  always @(posedge clk) begin
    if (rst) begin
      prevWrx = 1'b1;
    end else begin
      if (wrx && !prevWrx && !csx) begin
        actQ.push_back({dcx, data});
      end
      if (ack) begin
        ackCount++;
      end
      prevWrx = wrx;
    end
  end

  always @(posedge clk) begin : compare
    logic [8:0] expPair;
    logic [8:0] actPair;
    if (expQ.size() > 0 && actQ.size() > 0) begin
      expPair = expQ.pop_front();
      actPair = actQ.pop_front();
      assert (actPair[8] === expPair[8]) else begin
        byteErrors++;
        $display("[FAIL] %0t dcx expected %0b got %0b", $time, expPair[8], actPair[8]);
      end
      assert (actPair[7:0] === expPair[7:0]) else begin
        byteErrors++;
        $display("[FAIL] %0t data expected %02h got %02h", $time, expPair[7:0],
                 actPair[7:0]);
      end
    end
  end

  initial begin : watchdog
    int limitCycles;
    limitCycles = 16 + ackStep(opInit) + 6 * ackStep(opRed) + ackStep(opDispOff)
                + ackStep(opDispOn) + ackStep(opClear) + 9 * 8 + 2 * 6 + 100;
    #(limitCycles * clkPeriod);
    $display("timeout: run did not finish within %0d cycles", limitCycles);
    $display("STATUS: FAIL");
    $finish;
  end

  initial begin : stimulus
    lcdOp_t colours[5];
    lcdOp_t swapOp;
    logic [31:0] x;
    logic [31:0] y;
    int j;
    clk = 1'b0;
    rst = 1'b1;
    req = 1'b0;
    op = opNone;
    xWin = '0;
    yWin = '0;
    rngState = 32'd40817;
    colours = '{opRed, opGreen, opBlue, opBlack, opWhite};

    repeat (16) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    checkSignal("csx", 1, csx);
    checkSignal("wrx", 1, wrx);
    checkSignal("dcx", 1, dcx);
    checkSignal("data", 0, data);
    checkSignal("busy", 0, busy);
    checkSignal("ack", 0, ack);

    runOp(opInit, '0, '0, 1'b0);

    for (int i = 4; i > 0; i--) begin // shuffle the colour order
      rngState = xorshift32(rngState);
      j = rngState % (i + 1);
      swapOp = colours[i];
      colours[i] = colours[j];
      colours[j] = swapOp;
    end
    for (int i = 0; i < 5; i++) begin
      rngState = xorshift32(rngState);
      x = rngState;
      rngState = xorshift32(rngState);
      y = rngState;
      runOp(colours[i], x, y, 1'b0);
    end

    runOp(opDispOff, '0, '0, 1'b0);
    runOp(opDispOn, '0, '0, 1'b0);
    runOp(opClear, x, y, 1'b0); // windows are ignored for clear

    sendNoneRequest();
    sendNoneRequest();
    runOp(opGreen, ~y, ~x, 1'b1);

    repeat (4) @(posedge clk);
    assert (expQ.size() == 0) else begin
      ctrlErrors++;
      $display("%0d expected writes never appeared on the bus", expQ.size());
    end
    assert (actQ.size() == 0) else begin
      ctrlErrors++;
      $display("%0d unexpected writes appeared on the bus", actQ.size());
    end
    checkSignal("ack total", accepted, ackCount);

    $display("errors: bytes %0d, control %0d", byteErrors, ctrlErrors);
    if (byteErrors + ctrlErrors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

/* build.f */
+incdir+include
source/lcdPkg.sv
source/lcdCommandSelect.sv
source/lcdCycleCounter.sv
source/screenSignalLogic.sv
source/lcdTop.sv
verification/lcdTb.sv
